/* source/isa_pkg.sv */
`default_nettype none

package isa_pkg;

	// Every instruction field is one nibble wide
	localparam int FIELD_W = 4;

	// ==================================================
	// Opcodes
	// ==================================================
	// Codes above OP_XORI are undefined and dropped at decode
	typedef enum logic [FIELD_W-1:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_AND  = 4'h2,
		OP_OR   = 4'h3,
		OP_XOR  = 4'h4,
		OP_SHL  = 4'h5,
		OP_ADDI = 4'h6,
		OP_XORI = 4'h7
	} opcode_e;

	// ==================================================
	// Instruction formats
	// ==================================================
	// Register-register form
	typedef struct packed {
		logic [FIELD_W-1:0] opcode;
		logic [FIELD_W-1:0] rd;
		logic [FIELD_W-1:0] rs1;
		logic [FIELD_W-1:0] rs2;
	} inst_r_t;

	// Register-immediate form, imm is zero-extended
	typedef struct packed {
		logic [FIELD_W-1:0] opcode;
		logic [FIELD_W-1:0] rd;
		logic [FIELD_W-1:0] rs1;
		logic [FIELD_W-1:0] imm;
	} inst_i_t;

	// Same 16 bits, view picked by the opcode
	typedef union packed {
		inst_r_t r;
		inst_i_t i;
	} inst_word_u;

	// Opcode sits at the same place in both views
	function automatic logic op_defined(logic [FIELD_W-1:0] code);
		return code <= FIELD_W'(OP_XORI);
	endfunction

	function automatic logic op_is_imm(logic [FIELD_W-1:0] code);
		return (code == FIELD_W'(OP_ADDI)) || (code == FIELD_W'(OP_XORI));
	endfunction

endpackage

`default_nettype wire

/* source/sched_pkg.sv */
`default_nettype none

package sched_pkg;

	import isa_pkg::*;

	// ==================================================
	// Widths and depths
	// ==================================================
	localparam int DECODE_WIDTH   = 2;
	localparam int DISPATCH_WIDTH = 2;
	localparam int WB_WIDTH       = 2;
	// Power of two, pointers wrap naturally
	localparam int QUEUE_DEPTH    = 8;
	localparam int REG_NUM        = 16;
	localparam int REG_W          = 4;
	localparam int DATA_W         = 16;
	localparam int RES_FIFO_DEPTH = 4;

	// Derived pointer and count widths
	localparam int QPTR_W = $clog2(QUEUE_DEPTH);
	localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);
	localparam int RPTR_W = $clog2(RES_FIFO_DEPTH);
	localparam int RCNT_W = $clog2(RES_FIFO_DEPTH + 1);

	// ==================================================
	// Records
	// ==================================================
	// Producer bundle, slot 0 is older
	typedef struct packed {
		logic [DECODE_WIDTH-1:0] valid;
		inst_word_u [DECODE_WIDTH-1:0] inst;
	} fetch_bundle_t;

	// One dispatch queue slot
	typedef struct packed {
		opcode_e          op;
		logic [REG_W-1:0] pdest;
		logic [REG_W-1:0] src0;
		logic             src0_ready;
		logic [REG_W-1:0] src1;
		logic             src1_ready;
		logic             use_imm;
		logic [FIELD_W-1:0] imm;
	} dq_entry_t;

	// Write-back lane
	typedef struct packed {
		logic              valid;
		logic [REG_W-1:0]  pdest;
		logic [DATA_W-1:0] value;
	} wb_t;

	// Output record
	typedef struct packed {
		logic [REG_W-1:0]  rd;
		logic [DATA_W-1:0] value;
	} result_t;

endpackage

`default_nettype wire

/* source/inst_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decode
	import sched_pkg::*, isa_pkg::*;
(
	input  logic                           clk,
	input  logic                           rst_n,
	input  fetch_bundle_t                  bundle_i,
	input  logic                           req_i,
	output logic                           ack_o,
	output logic [DECODE_WIDTH-1:0]        wr_valid_o,
	output dq_entry_t [DECODE_WIDTH-1:0]   wr_data_o,
	input  logic                           write_ready_i,
	input  wb_t [WB_WIDTH-1:0]             wb_i
);

	typedef enum logic {HS_IDLE, HS_ACK} hs_state_e;

	hs_state_e               state_q;
	logic [REG_NUM-1:0]      busy_q, busy_set, busy_clr;
	logic [DECODE_WIDTH-1:0] slot_ok;
	logic                    dest_busy, dest_clash, accept;

	// Ready if r0, not busy, or written back this very cycle
	function automatic logic src_ready(logic [REG_W-1:0] r, logic [REG_NUM-1:0] busy,
			wb_t [WB_WIDTH-1:0] wb);
		logic rdy;
		rdy = (r == '0) || !busy[r];
		for (int j = 0; j < WB_WIDTH; j++) begin
			if (wb[j].valid && wb[j].pdest == r)
				rdy = 1'b1;
		end
		return rdy;
	endfunction

	// ==================================================
	// Slot decode
	// ==================================================
	always_comb begin
		for (int i = 0; i < DECODE_WIDTH; i++) begin
			slot_ok[i] = bundle_i.valid[i] && op_defined(bundle_i.inst[i].r.opcode);
			wr_data_o[i].op = opcode_e'(bundle_i.inst[i].r.opcode);
			if (op_is_imm(bundle_i.inst[i].r.opcode)) begin
				// Immediate view, second source pinned to r0
				wr_data_o[i].pdest   = bundle_i.inst[i].i.rd;
				wr_data_o[i].src0    = bundle_i.inst[i].i.rs1;
				wr_data_o[i].src1    = '0;
				wr_data_o[i].use_imm = 1'b1;
				wr_data_o[i].imm     = bundle_i.inst[i].i.imm;
			end else begin
				wr_data_o[i].pdest   = bundle_i.inst[i].r.rd;
				wr_data_o[i].src0    = bundle_i.inst[i].r.rs1;
				wr_data_o[i].src1    = bundle_i.inst[i].r.rs2;
				wr_data_o[i].use_imm = 1'b0;
				wr_data_o[i].imm     = '0;
			end
			wr_data_o[i].src0_ready = src_ready(wr_data_o[i].src0, busy_q, wb_i);
			wr_data_o[i].src1_ready = src_ready(wr_data_o[i].src1, busy_q, wb_i);
		end
		// Slot 1 reading slot 0's result waits for wake-up
		if (slot_ok[0] && wr_data_o[0].pdest != '0) begin
			if (wr_data_o[1].src0 == wr_data_o[0].pdest)
				wr_data_o[1].src0_ready = 1'b0;
			if (wr_data_o[1].src1 == wr_data_o[0].pdest)
				wr_data_o[1].src1_ready = 1'b0;
		end
	end

	// ==================================================
	// WAW stall and accept
	// ==================================================
	always_comb begin
		dest_busy = 1'b0;
		for (int i = 0; i < DECODE_WIDTH; i++) begin
			// r0 is never marked busy
			if (slot_ok[i] && busy_q[wr_data_o[i].pdest])
				dest_busy = 1'b1;
		end
		dest_clash = slot_ok[0] && slot_ok[1] && (wr_data_o[0].pdest != '0)
			&& (wr_data_o[0].pdest == wr_data_o[1].pdest);
		accept = (state_q == HS_IDLE) && req_i && write_ready_i && !dest_busy && !dest_clash;
		wr_valid_o = slot_ok & {DECODE_WIDTH{accept}};

		// Scoreboard updates
		busy_set = '0;
		busy_clr = '0;
		for (int i = 0; i < DECODE_WIDTH; i++) begin
			if (wr_valid_o[i] && wr_data_o[i].pdest != '0)
				busy_set[wr_data_o[i].pdest] = 1'b1;
		end
		for (int j = 0; j < WB_WIDTH; j++) begin
			if (wb_i[j].valid)
				busy_clr[wb_i[j].pdest] = 1'b1;
		end
	end

	// Handshake FSM and busy bits
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= HS_IDLE;
			busy_q  <= '0;
		end else begin
			case (state_q)
				HS_IDLE: if (accept) state_q <= HS_ACK;
				// Hold ack until the producer lets go of req
				HS_ACK:  if (!req_i) state_q <= HS_IDLE;
				default: state_q <= HS_IDLE;
			endcase
			busy_q <= (busy_q & ~busy_clr) | busy_set;
		end
	end

	assign ack_o = (state_q == HS_ACK);

endmodule

`default_nettype wire

/* source/dispatch_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch_queue
	import sched_pkg::*;
(
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [DECODE_WIDTH-1:0]         wr_valid_i,
	input  dq_entry_t [DECODE_WIDTH-1:0]    wr_data_i,
	output logic                            write_ready_o,
	output logic [DISPATCH_WIDTH-1:0]       rd_valid_o,
	output dq_entry_t [DISPATCH_WIDTH-1:0]  rd_data_o,
	input  logic [DISPATCH_WIDTH-1:0]       rd_ready_i,
	input  wb_t [WB_WIDTH-1:0]              wb_i
);

	// Entry storage
	dq_entry_t [QUEUE_DEPTH-1:0] mem_q, mem_n;

	// Pointers and occupancy
	logic [QPTR_W-1:0] head_q, tail_q;
	logic [QCNT_W-1:0] cnt_q;
	logic [QCNT_W-1:0] wr_cnt, rd_cnt;

	logic [DECODE_WIDTH-1:0]              wr_en;
	logic [DECODE_WIDTH-1:0][QPTR_W-1:0]  wr_ptr;
	logic [QPTR_W-1:0]                    wr_offs;

	// ==================================================
	// Read side
	// ==================================================
	always_comb begin
		for (int i = 0; i < DISPATCH_WIDTH; i++) begin
			rd_valid_o[i] = cnt_q > i;
			// Head and head plus one, wrapping
			rd_data_o[i] = mem_q[QPTR_W'(head_q + QPTR_W'(i))];
		end
		// Lane 1 only goes with lane 0, so a plain count is enough
		rd_cnt = QCNT_W'($countones(rd_ready_i & rd_valid_o));
	end

	// ==================================================
	// Write side
	// ==================================================
	// Room for a full bundle
	assign write_ready_o = cnt_q <= QCNT_W'(QUEUE_DEPTH - DECODE_WIDTH);

	always_comb begin
		wr_en   = wr_valid_i & {DECODE_WIDTH{write_ready_o}};
		wr_cnt  = QCNT_W'($countones(wr_en));
		// Valid slots are packed, no holes for an empty slot 0
		wr_offs = '0;
		for (int i = 0; i < DECODE_WIDTH; i++) begin
			wr_ptr[i] = tail_q + wr_offs;
			if (wr_en[i])
				wr_offs = wr_offs + 1'b1;
		end
	end

	// ==================================================
	// Wake-up and next state
	// ==================================================
	always_comb begin
		mem_n = mem_q;
		// Free slots get matched too, harmless since they are overwritten
		for (int e = 0; e < QUEUE_DEPTH; e++) begin
			for (int j = 0; j < WB_WIDTH; j++) begin
				if (wb_i[j].valid) begin
					if (mem_q[e].src0 == wb_i[j].pdest)
						mem_n[e].src0_ready = 1'b1;
					if (mem_q[e].src1 == wb_i[j].pdest)
						mem_n[e].src1_ready = 1'b1;
				end
			end
		end
		// New entries last, decode already folded in this cycle's write-back
		for (int i = 0; i < DECODE_WIDTH; i++) begin
			if (wr_en[i])
				mem_n[wr_ptr[i]] = wr_data_i[i];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head_q <= '0;
			tail_q <= '0;
			cnt_q  <= '0;
		end else begin
			head_q <= head_q + QPTR_W'(rd_cnt);
			tail_q <= tail_q + QPTR_W'(wr_cnt);
			cnt_q  <= cnt_q + wr_cnt - rd_cnt;
		end
	end

	// Entry payload
	always_ff @(posedge clk) begin
		mem_q <= mem_n;
	end

endmodule

`default_nettype wire

/* source/alu_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_execute
	import sched_pkg::*, isa_pkg::*;
(
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [DISPATCH_WIDTH-1:0]       rd_valid_i,
	input  dq_entry_t [DISPATCH_WIDTH-1:0]  rd_data_i,
	output logic [DISPATCH_WIDTH-1:0]       rd_ready_o,
	input  logic                            room_i,
	output wb_t [WB_WIDTH-1:0]              wb_o
);

	// Architectural registers
	logic [REG_NUM-1:0][DATA_W-1:0] rf_q;

	wb_t [WB_WIDTH-1:0]               wb_q, wb_n;
	logic [DISPATCH_WIDTH-1:0]        src_ok;
	logic [WB_WIDTH-1:0][DATA_W-1:0]  opa, opb;

	// One ALU lane
	function automatic logic [DATA_W-1:0] alu_op(opcode_e op, logic [DATA_W-1:0] a,
			logic [DATA_W-1:0] b);
		case (op)
			OP_ADD, OP_ADDI: return a + b;
			OP_SUB:          return a - b;
			OP_AND:          return a & b;
			OP_OR:           return a | b;
			OP_XOR, OP_XORI: return a ^ b;
			OP_SHL:          return a << b[$clog2(DATA_W)-1:0];
			default:         return '0;
		endcase
	endfunction

	// ==================================================
	// In-order issue
	// ==================================================
	always_comb begin
		for (int i = 0; i < DISPATCH_WIDTH; i++) begin
			src_ok[i] = rd_valid_i[i] && rd_data_i[i].src0_ready && rd_data_i[i].src1_ready;
		end
		// Result FIFO must have space for a full pair
		rd_ready_o[0] = src_ok[0] && room_i;
		for (int i = 1; i < DISPATCH_WIDTH; i++) begin
			rd_ready_o[i] = rd_ready_o[i-1] && src_ok[i];
		end
	end

	// Operand read and compute
	always_comb begin
		for (int i = 0; i < WB_WIDTH; i++) begin
			opa[i] = (rd_data_i[i].src0 == '0) ? '0 : rf_q[rd_data_i[i].src0];
			if (rd_data_i[i].use_imm)
				opb[i] = DATA_W'(rd_data_i[i].imm);
			else
				opb[i] = (rd_data_i[i].src1 == '0) ? '0 : rf_q[rd_data_i[i].src1];
			wb_n[i].valid = rd_ready_o[i];
			wb_n[i].pdest = rd_data_i[i].pdest;
			// A result aimed at r0 is reported as zero
			if (rd_data_i[i].pdest == '0)
				wb_n[i].value = '0;
			else
				wb_n[i].value = alu_op(rd_data_i[i].op, opa[i], opb[i]);
		end
	end

	// ==================================================
	// Write-back stage and register file
	// ==================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_q <= '0;
			rf_q <= '0;
		end else begin
			wb_q <= wb_n;
			// Later lane wins, though decode never lets two share a dest
			for (int i = 0; i < WB_WIDTH; i++) begin
				if (wb_q[i].valid && wb_q[i].pdest != '0)
					rf_q[wb_q[i].pdest] <= wb_q[i].value;
			end
		end
	end

	assign wb_o = wb_q;

endmodule

`default_nettype wire

/* source/result_commit.sv */
`timescale 1ns/1ps
`default_nettype none

module result_commit
	import sched_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  wb_t [WB_WIDTH-1:0] wb_i,
	output logic               room_o,
	output result_t            res_o,
	output logic               res_req_o,
	input  logic               res_ack_i
);

	typedef enum logic [1:0] {OUT_IDLE, OUT_REQ, OUT_WAIT} out_state_e;

	result_t [RES_FIFO_DEPTH-1:0] mem_q;
	result_t                      res_q;
	out_state_e                   state_q;

	logic [RPTR_W-1:0]                rptr_q, wptr_q;
	logic [RCNT_W-1:0]                cnt_q, push_cnt;
	logic [WB_WIDTH-1:0][RPTR_W-1:0]  push_ptr;
	logic                             pop, load;

	// ==================================================
	// FIFO control
	// ==================================================
	always_comb begin
		// Lane 0 first, valid lanes packed
		push_cnt = '0;
		for (int j = 0; j < WB_WIDTH; j++) begin
			push_ptr[j] = wptr_q + RPTR_W'(push_cnt);
			if (wb_i[j].valid)
				push_cnt = push_cnt + 1'b1;
		end
		pop  = (state_q == OUT_REQ) && res_ack_i;
		load = (state_q == OUT_IDLE) && (cnt_q != '0);
		// Two free slots left after this cycle's pushes, pops not counted
		room_o = (cnt_q + push_cnt) <= RCNT_W'(RES_FIFO_DEPTH - 2);
	end

	// Storage and output record
	always_ff @(posedge clk) begin
		for (int j = 0; j < WB_WIDTH; j++) begin
			if (wb_i[j].valid)
				mem_q[push_ptr[j]] <= '{rd: wb_i[j].pdest, value: wb_i[j].value};
		end
		if (load)
			res_q <= mem_q[rptr_q];
	end

	// ==================================================
	// Output four-phase FSM
	// ==================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= OUT_IDLE;
			rptr_q  <= '0;
			wptr_q  <= '0;
			cnt_q   <= '0;
		end else begin
			case (state_q)
				OUT_IDLE: if (load) state_q <= OUT_REQ;
				OUT_REQ:  if (res_ack_i) state_q <= OUT_WAIT;
				// Wait for ack low before the next request
				OUT_WAIT: if (!res_ack_i) state_q <= OUT_IDLE;
				default:  state_q <= OUT_IDLE;
			endcase
			wptr_q <= wptr_q + RPTR_W'(push_cnt);
			rptr_q <= rptr_q + RPTR_W'(pop);
			cnt_q  <= cnt_q + push_cnt - RCNT_W'(pop);
		end
	end

	assign res_req_o = (state_q == OUT_REQ);
	assign res_o     = res_q;

endmodule

`default_nettype wire

/* source/dispatch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch_top
	import sched_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n,
	input  fetch_bundle_t bundle_i,
	input  logic          req_i,
	output logic          ack_o,
	output result_t       res_o,
	output logic          res_req_o,
	input  logic          res_ack_i
);

	// Decode to queue
	logic [DECODE_WIDTH-1:0]        wr_valid;
	dq_entry_t [DECODE_WIDTH-1:0]   wr_data;
	logic                           write_ready;

	// Queue to execute
	logic [DISPATCH_WIDTH-1:0]      rd_valid;
	dq_entry_t [DISPATCH_WIDTH-1:0] rd_data;
	logic [DISPATCH_WIDTH-1:0]      rd_ready;

	// Write-back bus and result back-pressure
	wb_t [WB_WIDTH-1:0]             wb;
	logic                           room;

	// ==================================================
	// Pipeline
	// ==================================================
	inst_decode u_decode (
		.clk           (clk),
		.rst_n         (rst_n),
		.bundle_i      (bundle_i),
		.req_i         (req_i),
		.ack_o         (ack_o),
		.wr_valid_o    (wr_valid),
		.wr_data_o     (wr_data),
		.write_ready_i (write_ready),
		.wb_i          (wb)
	);

	dispatch_queue u_queue (
		.clk           (clk),
		.rst_n         (rst_n),
		.wr_valid_i    (wr_valid),
		.wr_data_i     (wr_data),
		.write_ready_o (write_ready),
		.rd_valid_o    (rd_valid),
		.rd_data_o     (rd_data),
		.rd_ready_i    (rd_ready),
		.wb_i          (wb)
	);

	alu_execute u_execute (
		.clk        (clk),
		.rst_n      (rst_n),
		.rd_valid_i (rd_valid),
		.rd_data_i  (rd_data),
		.rd_ready_o (rd_ready),
		.room_i     (room),
		.wb_o       (wb)
	);

	result_commit u_result (
		.clk       (clk),
		.rst_n     (rst_n),
		.wb_i      (wb),
		.room_o    (room),
		.res_o     (res_o),
		.res_req_o (res_req_o),
		.res_ack_i (res_ack_i)
	);

endmodule

`default_nettype wire

/* tests/tb_dispatch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dispatch_top
	import sched_pkg::*, isa_pkg::*;
();

	// Cycles any single wait may take
	localparam int WAIT_LIMIT = 5000;

	logic          clk;
	logic          rst_n;
	fetch_bundle_t bundle_i;
	logic          req_i;
	logic          ack_o;
	result_t       res_o;
	logic          res_req_o;
	logic          res_ack_i;

	// Model state and expected results in program order
	logic [DATA_W-1:0] ref_rf [REG_NUM];
	result_t           exp_q [$];
	integer            seed;
	int                ack_delay;
	bit                ack_rand;
	int                results_seen;

	dispatch_top DUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.bundle_i  (bundle_i),
		.req_i     (req_i),
		.ack_o     (ack_o),
		.res_o     (res_o),
		.res_req_o (res_req_o),
		.res_ack_i (res_ack_i)
	);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ==================================================
	// Error reporting and compare
	// ==================================================
	task automatic stop_run(input string what);
		$display("%s", what);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_val(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual)
			stop_run($sformatf("FAIL at %0t ns: %s expected 0x%0h got 0x%0h",
				$time, name, expected, actual));
	endtask

	// ==================================================
	// Stimulus builders and reference model
	// ==================================================
	function automatic inst_word_u encode_inst(logic [3:0] op, logic [3:0] rd,
			logic [3:0] rs1, logic [3:0] low);
		inst_word_u w;
		w = {op, rd, rs1, low};
		return w;
	endfunction

	function automatic fetch_bundle_t make_bundle(logic [1:0] v, inst_word_u i0,
			inst_word_u i1);
		fetch_bundle_t b;
		b.valid   = v;
		b.inst[0] = i0;
		b.inst[1] = i1;
		return b;
	endfunction

	// Applies slot 0 before slot 1 and never writes r0
	function automatic void ref_exec(input fetch_bundle_t b);
		logic [3:0]        op, rd, rs1, low;
		logic [DATA_W-1:0] a, c, v;
		result_t           r;
		for (int s = 0; s < DECODE_WIDTH; s++) begin
			{op, rd, rs1, low} = b.inst[s];
			if (b.valid[s] && (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
					OP_SHL, OP_ADDI, OP_XORI})) begin
				a = ref_rf[rs1];
				// Immediate is zero-extended
				if (op == OP_ADDI || op == OP_XORI)
					c = {{(DATA_W-4){1'b0}}, low};
				else
					c = ref_rf[low];
				case (op)
					OP_ADD, OP_ADDI: v = a + c;
					OP_SUB:          v = a - c;
					OP_AND:          v = a & c;
					OP_OR:           v = a | c;
					OP_SHL:          v = a << c[3:0];
					default:         v = a ^ c;
				endcase
				if (rd == 4'd0)
					v = '0;
				else
					ref_rf[rd] = v;
				r.rd    = rd;
				r.value = v;
				exp_q.push_back(r);
			end
		end
	endfunction

	// ==================================================
	// Producer, drain and random program
	// ==================================================
	task automatic send_bundle(input fetch_bundle_t b);
		int n;
		@(negedge clk);
		ref_exec(b);
		bundle_i = b;
		req_i    = 1'b1;
		n = 0;
		while (!ack_o) begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT)
				stop_run("Timeout: ack_o never rose for a pending bundle");
		end
		req_i = 1'b0;
		n = 0;
		while (ack_o) begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT)
				stop_run("Timeout: ack_o stayed high after req_i dropped");
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 || res_req_o || res_ack_i) begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT)
				stop_run($sformatf("Timeout: %0d expected results never arrived",
					exp_q.size()));
		end
	endtask

	task automatic run_random(input int count);
		inst_word_u  w [2];
		logic [1:0]  v;
		logic [3:0]  op;
		logic [31:0] r;
		repeat (count) begin
			r = $random(seed);
			v = r[1:0];
			for (int s = 0; s < 2; s++) begin
				r  = $random(seed);
				op = r[3:0];
				// Mostly defined opcodes with about one in eight left raw
				if (r[18:16] != 3'd0)
					op[3] = 1'b0;
				w[s] = encode_inst(op, r[7:4], r[11:8], r[15:12]);
			end
			// Two valid slots on one nonzero dest would stall forever
			if (v == 2'b11 && w[0].r.rd == w[1].r.rd && w[0].r.rd != 4'd0)
				w[1].r.rd = w[1].r.rd ^ 4'h1;
			send_bundle(make_bundle(v, w[0], w[1]));
		end
	endtask

	// ==================================================
	// Consumer and compare
	// ==================================================
	initial begin : consumer
		result_t     want;
		logic [31:0] r32;
		int          d;
		int          n;
		forever begin
			@(negedge clk);
			if (rst_n && res_req_o && !res_ack_i) begin
				r32 = $random(seed);
				d = ack_rand ? int'(r32[7:0]) % (ack_delay + 1) : ack_delay;
				repeat (d) @(negedge clk);
				if (exp_q.size() == 0)
					stop_run("Extra result: DUT produced a record the model did not expect");
				want = exp_q.pop_front();
				check_val("res_o.rd", 32'(want.rd), 32'(res_o.rd));
				check_val("res_o.value", 32'(want.value), 32'(res_o.value));
				results_seen++;
				res_ack_i = 1'b1;
				n = 0;
				while (res_req_o) begin
					@(negedge clk);
					n++;
					if (n > WAIT_LIMIT)
						stop_run("Timeout: res_req_o stayed high after res_ack_i");
				end
				res_ack_i = 1'b0;
			end
		end
	end

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin
		logic [3:0] da;
		logic [3:0] db;
		seed         = 32'haa1f;
		rst_n        = 1'b0;
		req_i        = 1'b0;
		res_ack_i    = 1'b0;
		bundle_i     = '0;
		ack_delay    = 0;
		ack_rand     = 1'b0;
		results_seen = 0;
		for (int k = 0; k < REG_NUM; k++)
			ref_rf[k] = '0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;

		// Quiet after reset
		check_val("ack_o", 32'd0, 32'(ack_o));
		check_val("res_req_o", 32'd0, 32'(res_req_o));
		repeat (10) begin
			@(negedge clk);
			check_val("ack_o", 32'd0, 32'(ack_o));
			check_val("res_req_o", 32'd0, 32'(res_req_o));
		end

		// Every opcode with immediates first to seed registers
		send_bundle(make_bundle(2'b11, encode_inst(OP_ADDI, 1, 0, 5),
			encode_inst(OP_ADDI, 2, 0, 3)));
		send_bundle(make_bundle(2'b11, encode_inst(OP_XORI, 3, 0, 15),
			encode_inst(OP_ADDI, 4, 0, 9)));
		send_bundle(make_bundle(2'b11, encode_inst(OP_ADD, 5, 1, 2),
			encode_inst(OP_SUB, 6, 2, 1)));
		send_bundle(make_bundle(2'b11, encode_inst(OP_AND, 7, 3, 4),
			encode_inst(OP_OR, 8, 3, 4)));
		send_bundle(make_bundle(2'b11, encode_inst(OP_XOR, 9, 1, 4),
			encode_inst(OP_SHL, 10, 3, 1)));
		wait_drain();

		// Chains inside a bundle and across bundles on the same dests
		for (int k = 0; k < 6; k++)
			send_bundle(make_bundle(2'b11, encode_inst(OP_ADDI, 11, 11, 1),
				encode_inst(OP_ADD, 12, 12, 11)));
		send_bundle(make_bundle(2'b11, encode_inst(OP_SHL, 13, 12, 2),
			encode_inst(OP_SUB, 14, 13, 12)));
		wait_drain();

		// r0 writes, invalid slots and undefined opcodes
		send_bundle(make_bundle(2'b11, encode_inst(OP_ADD, 0, 1, 2),
			encode_inst(OP_SUB, 0, 2, 1)));
		send_bundle(make_bundle(2'b01, encode_inst(OP_ADDI, 5, 5, 1),
			encode_inst(OP_ADDI, 5, 5, 2)));
		send_bundle(make_bundle(2'b11, encode_inst(4'hC, 6, 1, 1),
			encode_inst(OP_ADD, 6, 1, 1)));
		send_bundle(make_bundle(2'b10, encode_inst(OP_ADD, 7, 1, 1),
			encode_inst(OP_XORI, 7, 7, 6)));
		send_bundle(make_bundle(2'b00, encode_inst(OP_ADD, 8, 1, 1),
			encode_inst(OP_ADD, 9, 1, 1)));
		send_bundle(make_bundle(2'b11, encode_inst(OP_ADD, 7, 0, 0),
			encode_inst(OP_ADDI, 8, 0, 2)));
		wait_drain();

		// Slow consumer while the producer streams
		ack_delay = 30;
		for (int k = 0; k < 12; k++) begin
			da = 4'(1 + 2 * (k % 7));
			db = da + 4'd1;
			send_bundle(make_bundle(2'b11, encode_inst(OP_ADDI, da, da, 4'(k)),
				encode_inst(OP_XOR, db, da, db)));
		end
		wait_drain();

		// Random program with random ack delays
		ack_delay = 6;
		ack_rand  = 1'b1;
		run_random(200);
		wait_drain();
		repeat (20) @(negedge clk);

		if (exp_q.size() == 0 && results_seen > 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			stop_run("Run ended with results missing or none produced at all");
		end
	end

endmodule

`default_nettype wire

/* list.f */
source/isa_pkg.sv
source/sched_pkg.sv
source/inst_decode.sv
source/dispatch_queue.sv
source/alu_execute.sv
source/result_commit.sv
source/dispatch_top.sv
tests/tb_dispatch_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the dispatch testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing -Wno-fatal \
	-f list.f \
	--top-module tb_dispatch_top \
	--Mdir "$BUILD" -o tb_dispatch_top
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD/tb_dispatch_top" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi
exit 0
